// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary -f filelist.f --top-module tb_mem_unit -o sim_mem_unit
	./obj_dir/sim_mem_unit | tee /dev/stderr | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module mem_unit

clean:
	rm -rf obj_dir

// ==== filelist.f ====
rtl/mem_pkg.sv
rtl/mem_req_decode.sv
rtl/sram_sequencer.sv
rtl/mem_result.sv
rtl/mem_unit.sv
verif/sram_model.sv
verif/tb_mem_unit.sv

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// SRAM address and data
	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// Access tag from the CPU
	localparam int TAG_W = 32;

	// Phase counter, each phase lasts 2**PHASE_DIV_BITS cycles
	localparam int PHASE_DIV_BITS = 1;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	typedef enum logic [1:0] {
		KIND_EXE_READ  = 2'd0,
		KIND_EXE_WRITE = 2'd1,
		KIND_IF_READ   = 2'd2
	} mem_kind_e;

	typedef enum logic [2:0] {
		SEQ_IDLE = 3'd0,
		SEQ_RD1  = 3'd1,
		SEQ_RD2  = 3'd2,
		SEQ_RD3  = 3'd3,
		SEQ_WR1  = 3'd4,
		SEQ_WR2  = 3'd5,
		SEQ_WR3  = 3'd6
	} seq_state_e;

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////

	// One access as handed to the sequencer
	typedef struct packed {
		mem_kind_e         kind;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [TAG_W-1:0]  tag;
	} mem_op_t;

	// SRAM strobes, all active low
	typedef struct packed {
		logic en_n;
		logic oe_n;
		logic we_n;
	} sram_ctl_t;

	// Completion record, valid for one cycle
	typedef struct packed {
		logic              valid;
		mem_kind_e         kind;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] data;
	} mem_cap_t;

endpackage

// ==== rtl/mem_req_decode.sv ====
`timescale 1ns/1ps

module mem_req_decode import mem_pkg::*; (
	input  logic              need_if,
	input  logic              need_exe,
	input  logic              exe_read,
	input  logic              exe_write,
	input  logic [ADDR_W-1:0] addr_if,
	input  logic [ADDR_W-1:0] addr_exe,
	input  logic [DATA_W-1:0] wdata_exe,
	input  logic [TAG_W-1:0]  act,
	input  logic [TAG_W-1:0]  served_tag,
	input  logic              idle,
	output mem_op_t           op,
	output logic              start
);

	logic exe_valid;
	logic any_valid;
	logic act_new;

	// An execute request without a read or write flag does not count
	assign exe_valid = need_exe && (exe_read || exe_write);
	assign any_valid = exe_valid || need_if;

	// Tag already served means the current cycle is finished
	assign act_new = (act != served_tag);

	assign start = idle && any_valid && act_new;

	////////////////////////////////////////
	// Operation select
	////////////////////////////////////////

	always_comb begin
		op.tag   = act;
		op.wdata = wdata_exe;
		if (exe_valid) begin
			op.addr = addr_exe;
			// Read wins when both flags are set
			if (exe_read) begin
				op.kind = KIND_EXE_READ;
			end else begin
				op.kind = KIND_EXE_WRITE;
			end
		end else begin
			op.addr = addr_if;
			op.kind = KIND_IF_READ;
		end
	end

endmodule

// ==== rtl/mem_result.sv ====
`timescale 1ns/1ps

module mem_result import mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  mem_cap_t          cap,
	input  logic [TAG_W-1:0]  act,
	output logic [TAG_W-1:0]  served_tag,
	output logic [DATA_W-1:0] rdata_if,
	output logic [DATA_W-1:0] rdata_exe,
	output logic              done_if,
	output logic              done_exe
);

	logic last_exe;
	logic tag_match;

	////////////////////////////////////////
	// Served tag and stage
	////////////////////////////////////////

	// All ones after reset, never used as act
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			served_tag <= '1;
			last_exe   <= 1'b0;
		end else if (cap.valid) begin
			served_tag <= cap.tag;
			last_exe   <= (cap.kind != KIND_IF_READ);
		end
	end

	// Read results, writes leave both untouched
	always_ff @(posedge clk) begin
		if (cap.valid) begin
			if (cap.kind == KIND_IF_READ) begin
				rdata_if <= cap.data;
			end
			if (cap.kind == KIND_EXE_READ) begin
				rdata_exe <= cap.data;
			end
		end
	end

	////////////////////////////////////////
	// Done flags
	////////////////////////////////////////

	// New act drops done immediately
	assign tag_match = (served_tag == act);

	assign done_exe = tag_match && last_exe;
	assign done_if  = tag_match && !last_exe;

endmodule

// ==== rtl/mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit import mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// CPU side
	input  logic              need_if,
	input  logic              need_exe,
	input  logic              exe_read,
	input  logic              exe_write,
	input  logic [ADDR_W-1:0] addr_if,
	input  logic [ADDR_W-1:0] addr_exe,
	input  logic [DATA_W-1:0] wdata_exe,
	input  logic [TAG_W-1:0]  act,
	output logic              done_if,
	output logic              done_exe,
	output logic [DATA_W-1:0] rdata_if,
	output logic [DATA_W-1:0] rdata_exe,
	output logic [TAG_W-1:0]  served_tag,
	// SRAM side
	output logic [ADDR_W-1:0] sram_addr,
	inout  wire  [DATA_W-1:0] sram_data,
	output sram_ctl_t         sram_ctl
);

	mem_op_t  op;
	logic     start;
	logic     idle;
	mem_cap_t cap;

	mem_req_decode u_decode (
		.need_if    (need_if),
		.need_exe   (need_exe),
		.exe_read   (exe_read),
		.exe_write  (exe_write),
		.addr_if    (addr_if),
		.addr_exe   (addr_exe),
		.wdata_exe  (wdata_exe),
		.act        (act),
		.served_tag (served_tag),
		.idle       (idle),
		.op         (op),
		.start      (start)
	);

	sram_sequencer u_seq (
		.clk       (clk),
		.rst       (rst),
		.op        (op),
		.start     (start),
		.idle      (idle),
		.sram_addr (sram_addr),
		.sram_data (sram_data),
		.sram_ctl  (sram_ctl),
		.cap       (cap)
	);

	mem_result u_result (
		.clk        (clk),
		.rst        (rst),
		.cap        (cap),
		.act        (act),
		.served_tag (served_tag),
		.rdata_if   (rdata_if),
		.rdata_exe  (rdata_exe),
		.done_if    (done_if),
		.done_exe   (done_exe)
	);

endmodule

// ==== rtl/sram_sequencer.sv ====
`timescale 1ns/1ps

module sram_sequencer import mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  mem_op_t           op,
	input  logic              start,
	output logic              idle,
	output logic [ADDR_W-1:0] sram_addr,
	inout  wire  [DATA_W-1:0] sram_data,
	output sram_ctl_t         sram_ctl,
	output mem_cap_t          cap
);

	seq_state_e                state;
	logic [PHASE_DIV_BITS-1:0] phase_cnt;
	logic                      phase_end;
	logic                      bus_drive;
	logic                      last_phase;
	mem_op_t                   op_q;

	assign idle = (state == SEQ_IDLE);

	// Counter wraps on the last cycle of each phase
	assign phase_end = &phase_cnt;

	assign bus_drive = (state == SEQ_WR1) || (state == SEQ_WR2) || (state == SEQ_WR3);
	assign last_phase = (state == SEQ_RD3) || (state == SEQ_WR3);

	////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= SEQ_IDLE;
			phase_cnt <= '0;
		end else if (state == SEQ_IDLE) begin
			phase_cnt <= '0;
			if (start) begin
				if (op.kind == KIND_EXE_WRITE) begin
					state <= SEQ_WR1;
				end else begin
					state <= SEQ_RD1;
				end
			end
		end else begin
			phase_cnt <= phase_cnt + 1'b1;
			if (phase_end) begin
				case (state)
					SEQ_RD1: state <= SEQ_RD2;
					SEQ_RD2: state <= SEQ_RD3;
					SEQ_WR1: state <= SEQ_WR2;
					SEQ_WR2: state <= SEQ_WR3;
					default: state <= SEQ_IDLE;
				endcase
			end
		end
	end

	// Operation held for the whole access
	always_ff @(posedge clk) begin
		if (idle && start) begin
			op_q <= op;
		end
	end

	////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////

	assign sram_addr = op_q.addr;
	assign sram_data = bus_drive ? op_q.wdata : 'z;

	always_comb begin
		sram_ctl.en_n = 1'b1;
		sram_ctl.oe_n = 1'b1;
		sram_ctl.we_n = 1'b1;
		case (state)
			SEQ_RD1, SEQ_RD2, SEQ_RD3: begin
				sram_ctl.en_n = 1'b0;
				sram_ctl.oe_n = 1'b0;
			end
			SEQ_WR1, SEQ_WR3: begin
				sram_ctl.en_n = 1'b0;
			end
			// Write pulse only in the middle phase
			SEQ_WR2: begin
				sram_ctl.en_n = 1'b0;
				sram_ctl.we_n = 1'b0;
			end
			default: begin
				sram_ctl.en_n = 1'b1;
			end
		endcase
	end

	////////////////////////////////////////
	// Completion
	////////////////////////////////////////

	// Read data is taken from the bus at the end of phase three
	// During a write the bus carries the written word
	always_comb begin
		cap.valid = last_phase && phase_end;
		cap.kind  = op_q.kind;
		cap.tag   = op_q.tag;
		cap.data  = sram_data;
	end

endmodule

// ==== verif/sram_model.sv ====
`timescale 1ns/1ps

module sram_model import mem_pkg::*; (
	input  logic [ADDR_W-1:0] addr,
	inout  wire  [DATA_W-1:0] data,
	input  logic              en_n,
	input  logic              oe_n,
	input  logic              we_n
);

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
	logic              read_en;

	// Start-up contents, every address bit takes part
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return {a[17:16], 14'h1a5c} ^ a[15:0];
	endfunction

	initial begin
		for (int i = 0; i < (1 << ADDR_W); i++) begin
			mem[ADDR_W'(i)] = fill_word(ADDR_W'(i));
		end
	end

	// Word taken as the write strobe falls, bus is already stable by then
	always @(negedge we_n) begin
		if (!en_n) begin
			mem[addr] = data;
		end
	end

	assign read_en = !en_n && !oe_n && we_n;
	assign data = read_en ? mem[addr] : 'z;

endmodule

// ==== verif/tb_mem_unit.sv ====
`timescale 1ns/1ps

module tb_mem_unit import mem_pkg::*; ();

	logic              clk, rst;
	logic              need_if, need_exe, exe_read, exe_write;
	logic [ADDR_W-1:0] addr_if, addr_exe, last_addr;
	logic [DATA_W-1:0] wdata_exe, rdata_if, rdata_exe;
	logic [TAG_W-1:0]  act, served_tag, tag_count;
	logic              done_if, done_exe, saw_we_low, saw_oe_low;
	logic [ADDR_W-1:0] sram_addr;
	wire  [DATA_W-1:0] sram_data;
	sram_ctl_t         sram_ctl;
	logic [DATA_W-1:0] mirror [0:(1 << ADDR_W)-1];

	mem_unit dut (
		.clk(clk), .rst(rst), .need_if(need_if), .need_exe(need_exe),
		.exe_read(exe_read), .exe_write(exe_write), .addr_if(addr_if),
		.addr_exe(addr_exe), .wdata_exe(wdata_exe), .act(act), .done_if(done_if),
		.done_exe(done_exe), .rdata_if(rdata_if), .rdata_exe(rdata_exe),
		.served_tag(served_tag), .sram_addr(sram_addr), .sram_data(sram_data),
		.sram_ctl(sram_ctl)
	);

	sram_model u_sram (
		.addr(sram_addr), .data(sram_data), .en_n(sram_ctl.en_n),
		.oe_n(sram_ctl.oe_n), .we_n(sram_ctl.we_n)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	// Drive and sample point 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	// Same start-up contents as the SRAM model
	function automatic logic [DATA_W-1:0] start_value(input logic [ADDR_W-1:0] a);
		return {a[17:16], 14'h1a5c} ^ a[15:0];
	endfunction

	task automatic new_tag();
		tag_count = tag_count + 32'd1;
		act = tag_count;
	endtask

	// Polls one done flag while the other must stay low
	// Strobes and the address bus are watched on every poll
	task automatic wait_done(input logic exe, input logic [ADDR_W-1:0] a);
		int   n;
		logic got;
		got = 1'b0;
		n = 0;
		saw_we_low = 1'b0;
		saw_oe_low = 1'b0;
		while (!got && n < 40) begin
			step();
			if (!sram_ctl.we_n) saw_we_low = 1'b1;
			if (!sram_ctl.oe_n) saw_oe_low = 1'b1;
			if (!sram_ctl.en_n) check_eq("sram_addr", 32'(sram_addr), 32'(a));
			got = exe ? done_exe : done_if;
			check_eq(exe ? "done_if" : "done_exe", 32'(exe ? done_if : done_exe), 32'd0);
			n++;
		end
		if (!got) stop_with_error("Timed out waiting for a done flag");
		check_eq("served_tag", served_tag, act);
	endtask

	task automatic write_exe(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		logic [DATA_W-1:0] kept;
		kept = rdata_exe;
		new_tag();
		need_exe = 1'b1;
		exe_write = 1'b1;
		addr_exe = a;
		wdata_exe = d;
		wait_done(1'b1, a);
		check_eq("rdata_exe", 32'(rdata_exe), 32'(kept));
		mirror[a] = d;
		last_addr = a;
		need_exe = 1'b0;
		exe_write = 1'b0;
	endtask

	task automatic read_exe(input logic [ADDR_W-1:0] a);
		new_tag();
		need_exe = 1'b1;
		exe_read = 1'b1;
		addr_exe = a;
		wait_done(1'b1, a);
		check_eq("rdata_exe", 32'(rdata_exe), 32'(mirror[a]));
		need_exe = 1'b0;
		exe_read = 1'b0;
	endtask

	task automatic read_if(input logic [ADDR_W-1:0] a);
		logic [DATA_W-1:0] kept;
		kept = rdata_exe;
		new_tag();
		need_if = 1'b1;
		addr_if = a;
		wait_done(1'b0, a);
		check_eq("rdata_if", 32'(rdata_if), 32'(mirror[a]));
		check_eq("rdata_exe", 32'(rdata_exe), 32'(kept));
		need_if = 1'b0;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_write_read();
		write_exe(ADDR_W'($urandom), DATA_W'($urandom));
		read_exe(last_addr);
	endtask

	task automatic test_tag_rule();
		read_exe(ADDR_W'($urandom));
		need_exe = 1'b1;
		exe_read = 1'b1;
		repeat (6) begin
			step();
			check_eq("sram_ctl", 32'(sram_ctl), 32'h7);
			check_eq("done_exe", 32'(done_exe), 32'd1);
		end
		new_tag();
		#1;
		check_eq("done_exe", 32'(done_exe), 32'd0);
		wait_done(1'b1, addr_exe);
		check_eq("rdata_exe", 32'(rdata_exe), 32'(mirror[addr_exe]));
		need_exe = 1'b0;
		exe_read = 1'b0;
	endtask

	task automatic test_priority();
		new_tag();
		need_exe = 1'b1;
		exe_read = 1'b1;
		addr_exe = ADDR_W'($urandom);
		need_if = 1'b1;
		addr_if = ADDR_W'($urandom);
		wait_done(1'b1, addr_exe);
		check_eq("rdata_exe", 32'(rdata_exe), 32'(mirror[addr_exe]));
		need_exe = 1'b0;
		exe_read = 1'b0;
		new_tag();
		wait_done(1'b0, addr_if);
		check_eq("rdata_if", 32'(rdata_if), 32'(mirror[addr_if]));
		need_if = 1'b0;
	endtask

	task automatic test_strobes();
		write_exe(ADDR_W'($urandom), DATA_W'($urandom));
		check_eq("we_n low seen", 32'(saw_we_low), 32'd1);
		check_eq("oe_n low seen", 32'(saw_oe_low), 32'd0);
		read_exe(last_addr);
		check_eq("oe_n low seen", 32'(saw_oe_low), 32'd1);
		check_eq("we_n low seen", 32'(saw_we_low), 32'd0);
	endtask

	task automatic test_random();
		logic [ADDR_W-1:0] a;
		for (int i = 0; i < 20; i++) begin
			// Reads hit the last written word half of the time
			a = ($urandom % 2 == 0) ? last_addr : ADDR_W'($urandom);
			case ($urandom % 3)
				0: write_exe(ADDR_W'($urandom), DATA_W'($urandom));
				1: read_exe(a);
				default: read_if(a);
			endcase
		end
	endtask

	initial begin
		void'($urandom(32'h85a9_df67));
		rst = 1'b0;
		{need_if, need_exe, exe_read, exe_write} = 4'b0000;
		addr_if = '0;
		addr_exe = '0;
		last_addr = '0;
		wdata_exe = '0;
		act = '0;
		tag_count = '0;
		for (int i = 0; i < (1 << ADDR_W); i++) begin
			mirror[ADDR_W'(i)] = start_value(ADDR_W'(i));
		end
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b1;
		check_eq("served_tag", served_tag, 32'hffff_ffff);
		check_eq("sram_ctl", 32'(sram_ctl), 32'h7);
		test_write_read();
		read_if(ADDR_W'($urandom));
		test_tag_rule();
		test_priority();
		test_strobes();
		test_random();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
